// ==== hdl/mmu_defines.svh ====
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// ####################
// TLB geometry.
// ####################

`define MMU_TLB_ENTRIES 16
`define MMU_INDEX_W     4

// ####################
// Field widths.
// ####################

// Virtual page pair, vaddr bits 31..13.
`define MMU_VPN2_W      19
`define MMU_PFN_W       20
`define MMU_ASID_W      8

`endif

// ==== hdl/mmu_pkg.sv ====
`default_nettype none

`include "mmu_defines.svh"

package mmu_pkg;

    // One TLB entry, an even and odd page pair.
    typedef struct packed {
        logic [`MMU_VPN2_W-1:0] vpn2;
        logic [`MMU_ASID_W-1:0] asid;
        logic                   g;
        // Even page.
        logic [`MMU_PFN_W-1:0]  pfn0;
        logic [2:0]             c0;
        logic                   d0;
        logic                   v0;
        // Odd page.
        logic [`MMU_PFN_W-1:0]  pfn1;
        logic [2:0]             c1;
        logic                   d1;
        logic                   v1;
    } tlb_entry_t;

    typedef tlb_entry_t [`MMU_TLB_ENTRIES-1:0] tlb_table_t;

    // Translation faults, one per port.
    typedef enum logic [1:0] {
        FAULT_NONE     = 2'd0,
        FAULT_REFILL   = 2'd1,
        FAULT_INVALID  = 2'd2,
        FAULT_MODIFIED = 2'd3
    } fault_e;

endpackage

`default_nettype wire

// ==== hdl/direct_map.sv ====
`timescale 1ns/10ps
`default_nettype none

module direct_map (
    input  wire logic [31:0] i_vaddr,
    input  wire logic        i_k0_uncached,
    output logic      [31:0] o_paddr,
    output logic             o_uncached
);

    logic is_kseg0;
    logic is_kseg1;

    // Segment decode on the top three bits.
    assign is_kseg0 = (i_vaddr[31:29] == 3'b100);
    assign is_kseg1 = (i_vaddr[31:29] == 3'b101);

    // Both unmapped segments alias the low 512 MB.
    assign o_paddr = {3'b000, i_vaddr[28:0]};

    // kseg1 never cached, kseg0 per config bit.
    always_comb begin
        if (is_kseg1) begin
            o_uncached = 1'b1;
        end else if (is_kseg0) begin
            o_uncached = i_k0_uncached;
        end else begin
            o_uncached = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tlb_lut.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module tlb_lut
    import mmu_pkg::*;
(
    input  wire tlb_table_t                 i_table,
    input  wire logic [31:0]                i_vaddr,
    input  wire logic [`MMU_ASID_W-1:0]     i_asid,
    output logic                            o_hit,
    output logic      [`MMU_INDEX_W-1:0]    o_index,
    output logic      [`MMU_PFN_W-1:0]      o_pfn,
    output logic                            o_valid,
    output logic                            o_dirty,
    output logic      [2:0]                 o_cflag
);

    logic [`MMU_TLB_ENTRIES-1:0] match;
    logic [`MMU_INDEX_W-1:0]     sel;
    tlb_entry_t                  ent;
    logic                        odd;

    // ####################
    // Match mask.
    // ####################

    for (genvar i = 0; i < `MMU_TLB_ENTRIES; i++) begin : g_match
        assign match[i] = (i_table[i].vpn2 == i_vaddr[31:13]) &&
                          ((i_table[i].asid == i_asid) || i_table[i].g);
    end

    // Lowest matching index wins.
    always_comb begin
        sel = '0;
        for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel = `MMU_INDEX_W'(i);
            end
        end
    end

    // ####################
    // Page select.
    // ####################

    assign ent = i_table[sel];
    assign odd = i_vaddr[12];

    assign o_hit   = |match;
    assign o_index = sel;
    assign o_pfn   = odd ? ent.pfn1 : ent.pfn0;
    assign o_valid = odd ? ent.v1   : ent.v0;
    assign o_dirty = odd ? ent.d1   : ent.d0;
    assign o_cflag = odd ? ent.c1   : ent.c0;

endmodule

`default_nettype wire

// ==== hdl/tlb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module tlb
    import mmu_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       resetn,
    // Write and read ports.
    input  wire logic                       i_we,
    input  wire logic [`MMU_INDEX_W-1:0]    i_windex,
    input  wire tlb_entry_t                 i_wentry,
    input  wire logic [`MMU_INDEX_W-1:0]    i_rindex,
    output tlb_entry_t                      o_rentry,
    // Lookups.
    input  wire logic [`MMU_ASID_W-1:0]     i_asid,
    input  wire logic [31:0]                i_inst_vaddr,
    input  wire logic [31:0]                i_data_vaddr,
    input  wire logic [`MMU_VPN2_W-1:0]     i_probe_vpn2,
    output logic      [31:0]                o_inst_paddr,
    output logic                            o_inst_hit,
    output logic                            o_inst_valid,
    output logic      [31:0]                o_data_paddr,
    output logic                            o_data_hit,
    output logic                            o_data_valid,
    output logic                            o_data_dirty,
    output logic      [2:0]                 o_data_cflag,
    output logic                            o_probe_miss,
    output logic      [`MMU_INDEX_W-1:0]    o_probe_index
);

    tlb_table_t                  tlb_table;
    logic [`MMU_PFN_W-1:0]       inst_pfn;
    logic                        inst_hit;
    logic                        inst_valid;
    logic [`MMU_PFN_W-1:0]       data_pfn;
    logic                        data_hit;
    logic                        data_valid;
    logic                        data_dirty;
    logic [2:0]                  data_cflag;
    logic                        probe_hit;
    logic [31:0]                 probe_vaddr;

    // ####################
    // Entry table.
    // ####################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tlb_table <= '0;
        end else if (i_we) begin
            tlb_table[i_windex] <= i_wentry;
        end
    end

    assign o_rentry = tlb_table[i_rindex];

    // ####################
    // Lookups.
    // ####################

    tlb_lut u_inst_lut (
        .i_table (tlb_table),
        .i_vaddr (i_inst_vaddr),
        .i_asid  (i_asid),
        .o_hit   (inst_hit),
        .o_index (),
        .o_pfn   (inst_pfn),
        .o_valid (inst_valid),
        .o_dirty (),
        .o_cflag ()
    );

    tlb_lut u_data_lut (
        .i_table (tlb_table),
        .i_vaddr (i_data_vaddr),
        .i_asid  (i_asid),
        .o_hit   (data_hit),
        .o_index (),
        .o_pfn   (data_pfn),
        .o_valid (data_valid),
        .o_dirty (data_dirty),
        .o_cflag (data_cflag)
    );

    // Probe only looks at VPN2, low bits are don't care.
    assign probe_vaddr = {i_probe_vpn2, {(32 - `MMU_VPN2_W){1'b0}}};

    tlb_lut u_probe_lut (
        .i_table (tlb_table),
        .i_vaddr (probe_vaddr),
        .i_asid  (i_asid),
        .o_hit   (probe_hit),
        .o_index (o_probe_index),
        .o_pfn   (),
        .o_valid (),
        .o_dirty (),
        .o_cflag ()
    );

    assign o_probe_miss = ~probe_hit;

    // Registered lookup results.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_inst_paddr <= '0;
            o_inst_hit   <= 1'b0;
            o_inst_valid <= 1'b0;
            o_data_paddr <= '0;
            o_data_hit   <= 1'b0;
            o_data_valid <= 1'b0;
            o_data_dirty <= 1'b0;
            o_data_cflag <= '0;
        end else begin
            o_inst_paddr <= {inst_pfn, i_inst_vaddr[11:0]};
            o_inst_hit   <= inst_hit;
            o_inst_valid <= inst_valid;
            o_data_paddr <= {data_pfn, i_data_vaddr[11:0]};
            o_data_hit   <= data_hit;
            o_data_valid <= data_valid;
            o_data_dirty <= data_dirty;
            o_data_cflag <= data_cflag;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/translation_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module translation_unit
    import mmu_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       resetn,
    // Translation.
    input  wire logic                       i_k0_uncached,
    input  wire logic [31:0]                i_inst_vaddr,
    input  wire logic [31:0]                i_data_vaddr,
    output logic      [31:0]                o_inst_paddr,
    output logic                            o_inst_uncached,
    output fault_e                          o_inst_fault,
    output logic      [31:0]                o_data_paddr,
    output logic                            o_data_uncached,
    output fault_e                          o_data_fault,
    // TLBWI and the EntryHi/EntryLo fields.
    input  wire logic                       i_tlbwi,
    input  wire logic [`MMU_INDEX_W-1:0]    i_index,
    input  wire logic [`MMU_VPN2_W-1:0]     i_entryhi_vpn2,
    input  wire logic [`MMU_ASID_W-1:0]     i_entryhi_asid,
    input  wire logic [`MMU_PFN_W-1:0]      i_lo0_pfn,
    input  wire logic [2:0]                 i_lo0_c,
    input  wire logic                       i_lo0_d,
    input  wire logic                       i_lo0_v,
    input  wire logic                       i_lo0_g,
    input  wire logic [`MMU_PFN_W-1:0]      i_lo1_pfn,
    input  wire logic [2:0]                 i_lo1_c,
    input  wire logic                       i_lo1_d,
    input  wire logic                       i_lo1_v,
    input  wire logic                       i_lo1_g,
    // TLBR and TLBP.
    output logic      [`MMU_VPN2_W-1:0]     o_rd_vpn2,
    output logic      [`MMU_ASID_W-1:0]     o_rd_asid,
    output logic      [`MMU_PFN_W-1:0]      o_rd_lo0_pfn,
    output logic      [2:0]                 o_rd_lo0_c,
    output logic                            o_rd_lo0_d,
    output logic                            o_rd_lo0_v,
    output logic                            o_rd_lo0_g,
    output logic      [`MMU_PFN_W-1:0]      o_rd_lo1_pfn,
    output logic      [2:0]                 o_rd_lo1_c,
    output logic                            o_rd_lo1_d,
    output logic                            o_rd_lo1_v,
    output logic                            o_rd_lo1_g,
    output logic                            o_probe_miss,
    output logic      [`MMU_INDEX_W-1:0]    o_probe_index
);

    tlb_entry_t  wentry;
    tlb_entry_t  rentry;
    logic        inst_mapped;
    logic        data_mapped;
    logic [31:0] inst_tlb_paddr;
    logic [31:0] data_tlb_paddr;
    logic [31:0] inst_dir_paddr;
    logic [31:0] data_dir_paddr;
    logic        inst_dir_uncached;
    logic        data_dir_uncached;
    logic        inst_hit;
    logic        inst_valid;
    logic        data_hit;
    logic        data_valid;
    logic        data_dirty;
    logic [2:0]  data_cflag;

    // ####################
    // TLB instructions.
    // ####################

    // Entry is global only when both halves say so.
    assign wentry = '{vpn2: i_entryhi_vpn2, asid: i_entryhi_asid, g: i_lo0_g & i_lo1_g,
                      pfn0: i_lo0_pfn, c0: i_lo0_c, d0: i_lo0_d, v0: i_lo0_v,
                      pfn1: i_lo1_pfn, c1: i_lo1_c, d1: i_lo1_d, v1: i_lo1_v};

    assign o_rd_vpn2    = rentry.vpn2;
    assign o_rd_asid    = rentry.asid;
    assign o_rd_lo0_pfn = rentry.pfn0;
    assign o_rd_lo0_c   = rentry.c0;
    assign o_rd_lo0_d   = rentry.d0;
    assign o_rd_lo0_v   = rentry.v0;
    assign o_rd_lo0_g   = rentry.g;
    assign o_rd_lo1_pfn = rentry.pfn1;
    assign o_rd_lo1_c   = rentry.c1;
    assign o_rd_lo1_d   = rentry.d1;
    assign o_rd_lo1_v   = rentry.v1;
    assign o_rd_lo1_g   = rentry.g;

    tlb u_tlb (
        .clk           (clk),
        .resetn        (resetn),
        .i_we          (i_tlbwi),
        .i_windex      (i_index),
        .i_wentry      (wentry),
        .i_rindex      (i_index),
        .o_rentry      (rentry),
        .i_asid        (i_entryhi_asid),
        .i_inst_vaddr  (i_inst_vaddr),
        .i_data_vaddr  (i_data_vaddr),
        .i_probe_vpn2  (i_entryhi_vpn2),
        .o_inst_paddr  (inst_tlb_paddr),
        .o_inst_hit    (inst_hit),
        .o_inst_valid  (inst_valid),
        .o_data_paddr  (data_tlb_paddr),
        .o_data_hit    (data_hit),
        .o_data_valid  (data_valid),
        .o_data_dirty  (data_dirty),
        .o_data_cflag  (data_cflag),
        .o_probe_miss  (o_probe_miss),
        .o_probe_index (o_probe_index)
    );

    // ####################
    // Address select.
    // ####################

    // kuseg, kseg2 and kseg3 go through the TLB.
    assign inst_mapped = ~i_inst_vaddr[31] | (i_inst_vaddr[31:30] == 2'b11);
    assign data_mapped = ~i_data_vaddr[31] | (i_data_vaddr[31:30] == 2'b11);

    direct_map u_inst_dmap (
        .i_vaddr       (i_inst_vaddr),
        .i_k0_uncached (i_k0_uncached),
        .o_paddr       (inst_dir_paddr),
        .o_uncached    (inst_dir_uncached)
    );

    direct_map u_data_dmap (
        .i_vaddr       (i_data_vaddr),
        .i_k0_uncached (i_k0_uncached),
        .o_paddr       (data_dir_paddr),
        .o_uncached    (data_dir_uncached)
    );

    assign o_inst_paddr = inst_mapped ? inst_tlb_paddr : inst_dir_paddr;
    assign o_data_paddr = data_mapped ? data_tlb_paddr : data_dir_paddr;

    // Fetch through the TLB is reported cached.
    assign o_inst_uncached = inst_dir_uncached;
    assign o_data_uncached = data_dir_uncached | (data_mapped & (data_cflag != 3'd3));

    // Refill before invalid before modified.
    always_comb begin
        o_inst_fault = FAULT_NONE;
        if (inst_mapped) begin
            if (!inst_hit) begin
                o_inst_fault = FAULT_REFILL;
            end else if (!inst_valid) begin
                o_inst_fault = FAULT_INVALID;
            end
        end
    end

    always_comb begin
        o_data_fault = FAULT_NONE;
        if (data_mapped) begin
            if (!data_hit) begin
                o_data_fault = FAULT_REFILL;
            end else if (!data_valid) begin
                o_data_fault = FAULT_INVALID;
            end else if (!data_dirty) begin
                o_data_fault = FAULT_MODIFIED;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tu_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module tu_checker
    import mmu_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       i_check,
    input  wire logic [7:0]                 i_test,
    // DUT inputs.
    input  wire logic                       i_k0_uncached,
    input  wire logic [31:0]                i_inst_vaddr,
    input  wire logic [31:0]                i_data_vaddr,
    input  wire logic                       i_tlbwi,
    input  wire logic [`MMU_INDEX_W-1:0]    i_index,
    input  wire logic [`MMU_VPN2_W-1:0]     i_entryhi_vpn2,
    input  wire logic [`MMU_ASID_W-1:0]     i_entryhi_asid,
    input  wire logic [`MMU_PFN_W-1:0]      i_lo0_pfn,
    input  wire logic [2:0]                 i_lo0_c,
    input  wire logic                       i_lo0_d,
    input  wire logic                       i_lo0_v,
    input  wire logic                       i_lo0_g,
    input  wire logic [`MMU_PFN_W-1:0]      i_lo1_pfn,
    input  wire logic [2:0]                 i_lo1_c,
    input  wire logic                       i_lo1_d,
    input  wire logic                       i_lo1_v,
    input  wire logic                       i_lo1_g,
    // DUT outputs.
    input  wire logic [31:0]                i_inst_paddr,
    input  wire logic                       i_inst_uncached,
    input  wire fault_e                     i_inst_fault,
    input  wire logic [31:0]                i_data_paddr,
    input  wire logic                       i_data_uncached,
    input  wire fault_e                     i_data_fault,
    input  wire tlb_entry_t                 i_rd_entry,
    input  wire logic                       i_rd_lo1_g,
    input  wire logic                       i_probe_miss,
    input  wire logic [`MMU_INDEX_W-1:0]    i_probe_index,
    output int                              o_tests,
    output int                              o_errors
);

    tlb_entry_t shadow [`MMU_TLB_ENTRIES];
    logic       wrote;
    int         row_errors;

    initial begin
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        wrote    = 1'b0;
        o_tests  = 0;
        o_errors = 0;
    end

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("error at %0t: test %0d %s expected %h got %h", $time, i_test, what,
                     exp, got);
            row_errors++;
        end
    endtask

    // Lowest index whose VPN2 and ASID (or G) match.
    task automatic find_entry(input logic [18:0] vpn2, input logic [7:0] asid,
                              output logic hit, output int idx);
        hit = 1'b0;
        idx = 0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (!hit && shadow[i].vpn2 == vpn2 && (shadow[i].asid == asid || shadow[i].g)) begin
                hit = 1'b1;
                idx = i;
            end
        end
    endtask

    task automatic check_port(input string name, input logic is_data, input logic [31:0] va,
                              input logic [31:0] pa, input logic unc, input fault_e flt);
        logic       hit;
        int         idx;
        tlb_entry_t e;
        logic       odd;
        fault_e     exp_flt;
        if (va[31] && va[31:30] != 2'b11) begin
            // kseg0 and kseg1.
            compare({name, " paddr"}, {3'b000, va[28:0]}, pa);
            compare({name, " uncached"}, 32'(va[29] | i_k0_uncached), 32'(unc));
            compare({name, " fault"}, 32'(FAULT_NONE), 32'(flt));
        end else begin
            find_entry(va[31:13], i_entryhi_asid, hit, idx);
            e   = shadow[idx];
            odd = va[12];
            if (!hit) begin
                exp_flt = FAULT_REFILL;
            end else if (!(odd ? e.v1 : e.v0)) begin
                exp_flt = FAULT_INVALID;
            end else if (is_data && !(odd ? e.d1 : e.d0)) begin
                exp_flt = FAULT_MODIFIED;
            end else begin
                exp_flt = FAULT_NONE;
            end
            compare({name, " fault"}, 32'(exp_flt), 32'(flt));
            if (hit) begin
                compare({name, " paddr"}, {(odd ? e.pfn1 : e.pfn0), va[11:0]}, pa);
                compare({name, " uncached"},
                        32'(is_data && (odd ? e.c1 : e.c0) != 3'd3), 32'(unc));
            end
        end
    endtask

    task automatic run_checks();
        logic hit;
        int   idx;
        row_errors = 0;
        // TLBR of the indexed entry.
        compare("tlbr entry", 32'(i_rd_entry != shadow[i_index]), 32'd0);
        compare("tlbr lo1 g", 32'(shadow[i_index].g), 32'(i_rd_lo1_g));
        // TLBP over EntryHi.
        find_entry(i_entryhi_vpn2, i_entryhi_asid, hit, idx);
        compare("probe miss", 32'(!hit), 32'(i_probe_miss));
        if (hit) begin
            compare("probe index", 32'(idx), 32'(i_probe_index));
        end
        // Translation lags a write by a cycle, so write rows skip it.
        if (!wrote) begin
            check_port("inst", 1'b0, i_inst_vaddr, i_inst_paddr, i_inst_uncached, i_inst_fault);
            check_port("data", 1'b1, i_data_vaddr, i_data_paddr, i_data_uncached, i_data_fault);
        end
        o_tests++;
        o_errors += row_errors;
        if (row_errors == 0) begin
            $display("test %0d: ok", i_test);
        end else begin
            $display("test %0d: %0d mismatches", i_test, row_errors);
        end
    endtask

    always @(posedge clk) begin
        if (i_check) begin
            run_checks();
            wrote <= 1'b0;
        end
        if (i_tlbwi) begin
            shadow[i_index] <= '{vpn2: i_entryhi_vpn2, asid: i_entryhi_asid,
                                 g: i_lo0_g & i_lo1_g,
                                 pfn0: i_lo0_pfn, c0: i_lo0_c, d0: i_lo0_d, v0: i_lo0_v,
                                 pfn1: i_lo1_pfn, c1: i_lo1_c, d1: i_lo1_d, v1: i_lo1_v};
            wrote <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_translation_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module tb_translation_unit
    import mmu_pkg::*;
();

    typedef struct {
        bit          wi;
        logic [3:0]  index;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic [2:0]  dvg0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic [2:0]  dvg1;
        logic [31:0] iv;
        logic [31:0] dv;
        logic        k0;
    } row_t;

    logic        clk;
    logic        resetn;
    logic        k0_uncached;
    logic [31:0] inst_vaddr;
    logic [31:0] data_vaddr;
    logic        tlbwi;
    logic [3:0]  index;
    logic [18:0] vpn2;
    logic [7:0]  asid;
    logic [19:0] lo0_pfn;
    logic [2:0]  lo0_c;
    logic        lo0_d;
    logic        lo0_v;
    logic        lo0_g;
    logic [19:0] lo1_pfn;
    logic [2:0]  lo1_c;
    logic        lo1_d;
    logic        lo1_v;
    logic        lo1_g;
    logic [31:0] inst_paddr;
    logic        inst_uncached;
    fault_e      inst_fault;
    logic [31:0] data_paddr;
    logic        data_uncached;
    fault_e      data_fault;
    tlb_entry_t  rd;
    logic        rd_lo0_g;
    logic        rd_lo1_g;
    logic        probe_miss;
    logic [3:0]  probe_index;
    logic        check;
    logic [7:0]  test_num;
    int          tests;
    int          errors;
    row_t        rows [$];
    int          cycles;
    int          max_cycles;
    logic [31:0] offs;

    translation_unit u_dut (
        .clk (clk), .resetn (resetn), .i_k0_uncached (k0_uncached),
        .i_inst_vaddr (inst_vaddr), .i_data_vaddr (data_vaddr),
        .o_inst_paddr (inst_paddr), .o_inst_uncached (inst_uncached),
        .o_inst_fault (inst_fault), .o_data_paddr (data_paddr),
        .o_data_uncached (data_uncached), .o_data_fault (data_fault),
        .i_tlbwi (tlbwi), .i_index (index), .i_entryhi_vpn2 (vpn2), .i_entryhi_asid (asid),
        .i_lo0_pfn (lo0_pfn), .i_lo0_c (lo0_c), .i_lo0_d (lo0_d), .i_lo0_v (lo0_v),
        .i_lo0_g (lo0_g), .i_lo1_pfn (lo1_pfn), .i_lo1_c (lo1_c), .i_lo1_d (lo1_d),
        .i_lo1_v (lo1_v), .i_lo1_g (lo1_g),
        .o_rd_vpn2 (rd.vpn2), .o_rd_asid (rd.asid), .o_rd_lo0_pfn (rd.pfn0),
        .o_rd_lo0_c (rd.c0), .o_rd_lo0_d (rd.d0), .o_rd_lo0_v (rd.v0), .o_rd_lo0_g (rd_lo0_g),
        .o_rd_lo1_pfn (rd.pfn1), .o_rd_lo1_c (rd.c1), .o_rd_lo1_d (rd.d1),
        .o_rd_lo1_v (rd.v1), .o_rd_lo1_g (rd_lo1_g),
        .o_probe_miss (probe_miss), .o_probe_index (probe_index)
    );

    assign rd.g = rd_lo0_g;

    tu_checker u_chk (
        .clk (clk), .i_check (check), .i_test (test_num), .i_k0_uncached (k0_uncached),
        .i_inst_vaddr (inst_vaddr), .i_data_vaddr (data_vaddr), .i_tlbwi (tlbwi),
        .i_index (index), .i_entryhi_vpn2 (vpn2), .i_entryhi_asid (asid),
        .i_lo0_pfn (lo0_pfn), .i_lo0_c (lo0_c), .i_lo0_d (lo0_d), .i_lo0_v (lo0_v),
        .i_lo0_g (lo0_g), .i_lo1_pfn (lo1_pfn), .i_lo1_c (lo1_c), .i_lo1_d (lo1_d),
        .i_lo1_v (lo1_v), .i_lo1_g (lo1_g),
        .i_inst_paddr (inst_paddr), .i_inst_uncached (inst_uncached),
        .i_inst_fault (inst_fault), .i_data_paddr (data_paddr),
        .i_data_uncached (data_uncached), .i_data_fault (data_fault),
        .i_rd_entry (rd), .i_rd_lo1_g (rd_lo1_g),
        .i_probe_miss (probe_miss), .i_probe_index (probe_index),
        .o_tests (tests), .o_errors (errors)
    );

    // Entry write row with d/v/g packed as 3-bit fields.
    function automatic void add_write(input logic [3:0] idx, input logic [18:0] vpn,
                                      input logic [7:0] id, input logic [19:0] p0,
                                      input logic [2:0] c0, input logic [2:0] dvg0,
                                      input logic [19:0] p1, input logic [2:0] c1,
                                      input logic [2:0] dvg1);
        row_t r;
        r = '{wi: 1'b1, index: idx, vpn2: vpn, asid: id, pfn0: p0, c0: c0, dvg0: dvg0,
              pfn1: p1, c1: c1, dvg1: dvg1, iv: 32'h8000_0000, dv: 32'h8000_0000, k0: 1'b0};
        rows.push_back(r);
    endfunction

    // Translate row whose vpn and idx feed TLBP and TLBR.
    function automatic void add_translate(input logic [31:0] iv, input logic [31:0] dv,
                                          input logic [7:0] id, input logic k0,
                                          input logic [18:0] vpn, input logic [3:0] idx);
        row_t r;
        r = '{wi: 1'b0, index: idx, vpn2: vpn, asid: id, pfn0: '0, c0: '0, dvg0: '0,
              pfn1: '0, c1: '0, dvg1: '0, iv: iv, dv: dv, k0: k0};
        rows.push_back(r);
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("Timeout after %0d cycles, the stimulus loop did not finish.", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        // ####################
        // Stimulus table.
        // ####################
        add_translate(32'h8000_1000, 32'hA000_5000, 8'h01, 1'b0, 19'h00000, 4'd0);
        add_translate(32'h9FFF_F000, 32'h8000_0000, 8'h01, 1'b1, 19'h00200, 4'd2);
        add_write(4'd3, 19'h00200, 8'h01, 20'h12345, 3'd3, 3'b110, 20'h23456, 3'd2, 3'b011);
        add_translate(32'h0040_0000, 32'h0040_1000, 8'h01, 1'b0, 19'h00200, 4'd3);
        add_translate(32'h0040_1000, 32'h0040_0000, 8'h01, 1'b0, 19'h00200, 4'd3);
        add_translate(32'h0040_0000, 32'h0040_1000, 8'h02, 1'b0, 19'h00200, 4'd3);
        add_write(4'd5, 19'h60000, 8'h07, 20'h00ABC, 3'd3, 3'b001, 20'h00DEF, 3'd3, 3'b111);
        add_translate(32'hC000_0000, 32'hC000_1000, 8'h02, 1'b0, 19'h60000, 4'd5);
        add_translate(32'hC000_1000, 32'hC000_0000, 8'h07, 1'b0, 19'h60000, 4'd5);
        add_write(4'd1, 19'h00200, 8'h01, 20'h0F00F, 3'd3, 3'b111, 20'h0F00E, 3'd3, 3'b111);
        add_translate(32'h0040_1000, 32'h0040_0000, 8'h01, 1'b0, 19'h00200, 4'd1);
        add_translate(32'h8000_2000, 32'h0040_1000, 8'h05, 1'b1, 19'h12345, 4'd3);
        add_write(4'd0, 19'h7FFFF, 8'h03, 20'hFFFFF, 3'd0, 3'b110, 20'h11111, 3'd3, 3'b110);
        add_translate(32'hFFFF_E000, 32'hFFFF_E000, 8'h03, 1'b0, 19'h7FFFF, 4'd0);
        add_translate(32'hFFFF_F000, 32'h0040_1000, 8'h03, 1'b0, 19'h00200, 4'd5);

        max_cycles  = 2 * rows.size() + 20;
        cycles      = 0;
        void'($urandom(56));
        resetn      = 1'b0;
        k0_uncached = 1'b0;
        inst_vaddr  = 32'h8000_0000;
        data_vaddr  = 32'h8000_0000;
        {tlbwi, index, vpn2, asid} = '0;
        {lo0_pfn, lo0_c, lo0_d, lo0_v, lo0_g} = '0;
        {lo1_pfn, lo1_c, lo1_d, lo1_v, lo1_g} = '0;
        check       = 1'b0;
        test_num    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        foreach (rows[n]) begin
            @(negedge clk);
            check    = 1'b0;
            test_num = 8'(n);
            tlbwi    = rows[n].wi;
            index    = rows[n].index;
            vpn2     = rows[n].vpn2;
            asid     = rows[n].asid;
            {lo0_pfn, lo0_c, lo0_d, lo0_v, lo0_g} = {rows[n].pfn0, rows[n].c0, rows[n].dvg0};
            {lo1_pfn, lo1_c, lo1_d, lo1_v, lo1_g} = {rows[n].pfn1, rows[n].c1, rows[n].dvg1};
            if (!rows[n].wi) begin
                offs        = $urandom();
                inst_vaddr  = {rows[n].iv[31:12], offs[11:0]};
                offs        = $urandom();
                data_vaddr  = {rows[n].dv[31:12], offs[11:0]};
                k0_uncached = rows[n].k0;
            end
            @(negedge clk);
            tlbwi = 1'b0;
            check = 1'b1;
        end
        @(negedge clk);
        check = 1'b0;
        @(negedge clk);

        $display("tests run %0d of %0d, errors %0d", tests, rows.size(), errors);
        if (errors == 0 && tests == rows.size()) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/mmu_pkg.sv
hdl/direct_map.sv
hdl/tlb_lut.sv
hdl/tlb.sv
hdl/translation_unit.sv
testbench/tu_checker.sv
testbench/tb_translation_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the translation unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary -j 0 -f vlog.f --top-module tb_translation_unit -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status."
    exit 1
fi

"./$OBJ/Vtb_translation_unit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG."
    exit 1
fi
